// ==== axi_lite_reg_bridge.f ====
+incdir+hw
hw/axi_full_pkg.sv
hw/axi_lite_pkg.sv
hw/axi_bus_if.sv
hw/id_fifo.sv
hw/axi_burst_splitter.sv
hw/axi_lite_id_reflect.sv
hw/axi_lite_regfile.sv
hw/axi_lite_reg_bridge.sv
sim/axi_lite_reg_bridge_asserts.sv
sim/axi_lite_reg_bridge_tb.sv

// ==== hw/axi_bridge_consts.svh ====
// Widths, limits and sizes of the AXI to AXI-Lite register bridge, included by packages and RTL
`ifndef AXI_BRIDGE_CONSTS_SVH
`define AXI_BRIDGE_CONSTS_SVH

// Full AXI bus widths
`define AXI_ID_W 4
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// Longest burst length field, so at most 8 beats
`define AXI_MAX_LEN 7

// Default depth of each ID FIFO in the reflector
`define AXI_MAX_TXNS 4

// Register file size, byte range 0x00 to 0x3F
`define REG_COUNT 16

`endif

// ==== hw/axi_burst_splitter.sv ====
// Splits full-AXI INCR bursts into single beats for the reflector and merges their responses
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module axi_burst_splitter (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_full_pkg::id_t   aw_id_i,
  input  axi_full_pkg::addr_t aw_addr_i,
  input  axi_full_pkg::len_t  aw_len_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  axi_full_pkg::data_t w_data_i,
  input  axi_full_pkg::strb_t w_strb_i,
  input  logic                w_last_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output axi_full_pkg::id_t   b_id_o,
  output axi_full_pkg::resp_t b_resp_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  axi_full_pkg::id_t   ar_id_i,
  input  axi_full_pkg::addr_t ar_addr_i,
  input  axi_full_pkg::len_t  ar_len_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output axi_full_pkg::id_t   r_id_o,
  output axi_full_pkg::data_t r_data_o,
  output axi_full_pkg::resp_t r_resp_o,
  output logic                r_last_o,
  axi_beat_if.mgr             beat
);
  import axi_full_pkg::*;

  // Remaining-beat counter sized for the longest burst
  localparam int unsigned CNT_W = $clog2(`AXI_MAX_LEN + 1);
  typedef logic [CNT_W-1:0] cnt_t;

  split_state_t wr_state_q;
  split_state_t rd_state_q;
  id_t          wr_id_q;
  id_t          rd_id_q;
  addr_t        wr_addr_q;
  addr_t        rd_addr_q;
  cnt_t         wr_left_q;
  cnt_t         rd_left_q;
  resp_t        wr_resp_q;
  logic         wr_last_q;
  logic         wr_final;
  logic         rd_final;

  // SLVERR outranks OKAY
  function automatic resp_t worse(input resp_t a, input resp_t b);
    return (b > a) ? b : a;
  endfunction

  // Inner AW and W of one write beat travel together
  assign wr_final       = wr_last_q | (wr_left_q == '0);
  assign aw_ready_o     = (wr_state_q == IDLE) & ~reset_i;
  assign beat.aw_valid  = (wr_state_q == WR_BEAT) & w_valid_i;
  assign beat.aw_id     = wr_id_q;
  assign beat.aw_addr   = wr_addr_q;
  assign beat.w_valid   = (wr_state_q == WR_BEAT) & w_valid_i;
  assign beat.w_data    = w_data_i;
  assign beat.w_strb    = w_strb_i;
  assign w_ready_o      = (wr_state_q == WR_BEAT) & beat.w_ready;

  // Inner B of earlier beats is absorbed, the last one goes out merged
  assign beat.b_ready   = (wr_state_q == WR_RESP) & (~wr_final | b_ready_i);
  assign b_valid_o      = (wr_state_q == WR_RESP) & wr_final & beat.b_valid;
  assign b_id_o         = beat.b_id;
  assign b_resp_o       = worse(wr_resp_q, beat.b_resp);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= IDLE;
      wr_left_q  <= '0;
      wr_last_q  <= 1'b0;
    end else begin
      case (wr_state_q)
        IDLE: begin
          if (aw_valid_i) begin
            wr_id_q    <= aw_id_i;
            wr_addr_q  <= aw_addr_i;
            wr_left_q  <= cnt_t'(aw_len_i);
            wr_resp_q  <= RESP_OKAY;
            wr_last_q  <= 1'b0;
            wr_state_q <= WR_BEAT;
          end
        end
        WR_BEAT: begin
          if (beat.w_valid && beat.w_ready) begin
            wr_last_q  <= w_last_i;
            wr_state_q <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (beat.b_valid && beat.b_ready) begin
            wr_resp_q <= worse(wr_resp_q, beat.b_resp);
            if (wr_final) begin
              wr_state_q <= IDLE;
            end else begin
              wr_addr_q  <= wr_addr_q + addr_t'(4);
              wr_left_q  <= wr_left_q - cnt_t'(1);
              wr_state_q <= WR_BEAT;
            end
          end
        end
        default: wr_state_q <= IDLE;
      endcase
    end
  end

  // Read path issues one inner AR at a time
  assign rd_final       = (rd_left_q == '0);
  assign ar_ready_o     = (rd_state_q == IDLE) & ~reset_i;
  assign beat.ar_valid  = (rd_state_q == RD_BEAT);
  assign beat.ar_id     = rd_id_q;
  assign beat.ar_addr   = rd_addr_q;
  assign beat.r_ready   = (rd_state_q == RD_DATA) & r_ready_i;
  assign r_valid_o      = (rd_state_q == RD_DATA) & beat.r_valid;
  assign r_id_o         = beat.r_id;
  assign r_data_o       = beat.r_data;
  assign r_resp_o       = beat.r_resp;
  assign r_last_o       = r_valid_o & rd_final;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_state_q <= IDLE;
      rd_left_q  <= '0;
    end else begin
      case (rd_state_q)
        IDLE: begin
          if (ar_valid_i) begin
            rd_id_q    <= ar_id_i;
            rd_addr_q  <= ar_addr_i;
            rd_left_q  <= cnt_t'(ar_len_i);
            rd_state_q <= RD_BEAT;
          end
        end
        RD_BEAT: begin
          if (beat.ar_ready) begin
            rd_state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (beat.r_valid && beat.r_ready) begin
            if (rd_final) begin
              rd_state_q <= IDLE;
            end else begin
              rd_addr_q  <= rd_addr_q + addr_t'(4);
              rd_left_q  <= rd_left_q - cnt_t'(1);
              rd_state_q <= RD_BEAT;
            end
          end
        end
        default: rd_state_q <= IDLE;
      endcase
    end
  end

endmodule

// ==== hw/axi_bus_if.sv ====
// Internal buses of the bridge: single-beat full AXI and AXI-Lite, instantiated by the top level
`timescale 1ns/1ps

interface axi_beat_if;
  import axi_full_pkg::*;

  logic  aw_valid;
  logic  aw_ready;
  id_t   aw_id;
  addr_t aw_addr;
  logic  w_valid;
  logic  w_ready;
  data_t w_data;
  strb_t w_strb;
  logic  b_valid;
  logic  b_ready;
  id_t   b_id;
  resp_t b_resp;
  logic  ar_valid;
  logic  ar_ready;
  id_t   ar_id;
  addr_t ar_addr;
  logic  r_valid;
  logic  r_ready;
  id_t   r_id;
  data_t r_data;
  resp_t r_resp;

  modport mgr (
    output aw_valid, aw_id, aw_addr, w_valid, w_data, w_strb, b_ready,
    output ar_valid, ar_id, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_id, b_resp,
    input  ar_ready, r_valid, r_id, r_data, r_resp
  );

  modport sub (
    input  aw_valid, aw_id, aw_addr, w_valid, w_data, w_strb, b_ready,
    input  ar_valid, ar_id, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_id, b_resp,
    output ar_ready, r_valid, r_id, r_data, r_resp
  );
endinterface

// Same channels without IDs
interface axi_lite_if;
  import axi_full_pkg::*;
  import axi_lite_pkg::*;

  logic       aw_valid;
  logic       aw_ready;
  addr_t      aw_addr;
  logic       w_valid;
  logic       w_ready;
  data_t      w_data;
  strb_t      w_strb;
  logic       b_valid;
  logic       b_ready;
  lite_resp_t b_resp;
  logic       ar_valid;
  logic       ar_ready;
  addr_t      ar_addr;
  logic       r_valid;
  logic       r_ready;
  data_t      r_data;
  lite_resp_t r_resp;

  modport mgr (
    output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

  modport sub (
    input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );
endinterface

// ==== hw/axi_full_pkg.sv ====
// Types of the full AXI side of the bridge, imported by the splitter, FIFO and internal bus
`include "axi_bridge_consts.svh"

package axi_full_pkg;

  typedef logic [`AXI_ID_W-1:0] id_t;
  typedef logic [`AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_DATA_W-1:0] data_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;

  // Beats minus one, as on AxLEN
  typedef logic [7:0] len_t;

  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Write path uses IDLE, WR_BEAT, WR_RESP and read path IDLE, RD_BEAT, RD_DATA
  typedef enum logic [2:0] {
    IDLE,
    WR_BEAT,
    WR_RESP,
    RD_BEAT,
    RD_DATA
  } split_state_t;

endpackage

// ==== hw/axi_lite_id_reflect.sv ====
// Converts single-beat full AXI to AXI-Lite and reflects request IDs onto the responses
`timescale 1ns/1ps

module axi_lite_id_reflect (
  input logic     clk_i,
  input logic     reset_i,
  axi_beat_if.sub beat,
  axi_lite_if.mgr lite
);

  logic aw_full;
  logic aw_empty;
  logic aw_push;
  logic aw_pop;
  logic ar_full;
  logic ar_empty;
  logic ar_push;
  logic ar_pop;

  // Requests stall while their ID FIFO is full
  assign lite.aw_valid = beat.aw_valid & ~aw_full;
  assign beat.aw_ready = lite.aw_ready & ~aw_full;
  assign lite.aw_addr  = beat.aw_addr;
  assign lite.w_valid  = beat.w_valid;
  assign beat.w_ready  = lite.w_ready;
  assign lite.w_data   = beat.w_data;
  assign lite.w_strb   = beat.w_strb;
  assign lite.ar_valid = beat.ar_valid & ~ar_full;
  assign beat.ar_ready = lite.ar_ready & ~ar_full;
  assign lite.ar_addr  = beat.ar_addr;

  // Responses wait for an ID to return with
  assign beat.b_valid  = lite.b_valid & ~aw_empty;
  assign lite.b_ready  = beat.b_ready & ~aw_empty;
  assign beat.b_resp   = lite.b_resp;
  assign beat.r_valid  = lite.r_valid & ~ar_empty;
  assign lite.r_ready  = beat.r_ready & ~ar_empty;
  assign beat.r_data   = lite.r_data;
  assign beat.r_resp   = lite.r_resp;

  assign aw_push = beat.aw_valid & beat.aw_ready;
  assign aw_pop  = beat.b_valid & beat.b_ready;
  assign ar_push = beat.ar_valid & beat.ar_ready;
  assign ar_pop  = beat.r_valid & beat.r_ready;

  id_fifo i_aw_id_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (aw_push),
    .data_i  (beat.aw_id),
    .pop_i   (aw_pop),
    .data_o  (beat.b_id),
    .full_o  (aw_full),
    .empty_o (aw_empty)
  );

  id_fifo i_ar_id_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (ar_push),
    .data_i  (beat.ar_id),
    .pop_i   (ar_pop),
    .data_o  (beat.r_id),
    .full_o  (ar_full),
    .empty_o (ar_empty)
  );

endmodule

// ==== hw/axi_lite_pkg.sv ====
// Types of the AXI-Lite side of the bridge, imported by the Lite bus and the register file
`include "axi_bridge_consts.svh"

package axi_lite_pkg;

  // Word index into the register array
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

  // Lite responses keep the full-side encoding
  typedef axi_full_pkg::resp_t lite_resp_t;

  typedef enum logic [1:0] {
    IDLE,
    B_PEND,
    R_PEND
  } lite_state_t;

endpackage

// ==== hw/axi_lite_reg_bridge.sv ====
// Top level of the AXI4 to AXI4-Lite register bridge, driven by a full-AXI manager on plain ports
`timescale 1ns/1ps

module axi_lite_reg_bridge (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_full_pkg::id_t   aw_id_i,
  input  axi_full_pkg::addr_t aw_addr_i,
  input  axi_full_pkg::len_t  aw_len_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  axi_full_pkg::data_t w_data_i,
  input  axi_full_pkg::strb_t w_strb_i,
  input  logic                w_last_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output axi_full_pkg::id_t   b_id_o,
  output axi_full_pkg::resp_t b_resp_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  axi_full_pkg::id_t   ar_id_i,
  input  axi_full_pkg::addr_t ar_addr_i,
  input  axi_full_pkg::len_t  ar_len_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output axi_full_pkg::id_t   r_id_o,
  output axi_full_pkg::data_t r_data_o,
  output axi_full_pkg::resp_t r_resp_o,
  output logic                r_last_o
);

  // Single beats from splitter to reflector
  axi_beat_if beat ();
  // ID-free Lite bus into the register file
  axi_lite_if lite ();

  axi_burst_splitter i_axi_burst_splitter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_id_i    (aw_id_i),
    .aw_addr_i  (aw_addr_i),
    .aw_len_i   (aw_len_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_id_o     (b_id_o),
    .b_resp_o   (b_resp_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_id_i    (ar_id_i),
    .ar_addr_i  (ar_addr_i),
    .ar_len_i   (ar_len_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_id_o     (r_id_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .beat       (beat.mgr)
  );

  axi_lite_id_reflect i_axi_lite_id_reflect (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .beat    (beat.sub),
    .lite    (lite.mgr)
  );

  axi_lite_regfile i_axi_lite_regfile (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .lite    (lite.sub)
  );

endmodule

// ==== hw/axi_lite_regfile.sv ====
// AXI-Lite register file of 16 words with byte strobes, answering SLVERR outside its range
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module axi_lite_regfile (
  input logic     clk_i,
  input logic     reset_i,
  axi_lite_if.sub lite
);
  import axi_full_pkg::*;
  import axi_lite_pkg::*;

  // First byte address past the registers
  localparam addr_t RANGE_END = addr_t'(`REG_COUNT * 4);

  lite_state_t state_q;
  data_t       regs_q [`REG_COUNT];
  data_t       rdata_q;
  resp_t       resp_q;
  reg_idx_t    wr_idx;
  reg_idx_t    rd_idx;
  logic        wr_ok;
  logic        rd_ok;
  logic        wr_go;
  logic        rd_go;

  assign wr_idx = reg_idx_t'(lite.aw_addr >> 2);
  assign rd_idx = reg_idx_t'(lite.ar_addr >> 2);
  assign wr_ok  = (lite.aw_addr < RANGE_END);
  assign rd_ok  = (lite.ar_addr < RANGE_END);

  // IDLE is named in both packages, so it is scoped here
  // A write needs AW and W together and wins over a read
  assign wr_go = (state_q == axi_lite_pkg::IDLE) & lite.aw_valid & lite.w_valid;
  assign rd_go = (state_q == axi_lite_pkg::IDLE) & lite.ar_valid & ~wr_go;

  assign lite.aw_ready = wr_go;
  assign lite.w_ready  = wr_go;
  assign lite.ar_ready = rd_go;
  assign lite.b_valid  = (state_q == B_PEND);
  assign lite.b_resp   = resp_q;
  assign lite.r_valid  = (state_q == R_PEND);
  assign lite.r_resp   = resp_q;
  assign lite.r_data   = rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= axi_lite_pkg::IDLE;
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      case (state_q)
        axi_lite_pkg::IDLE: begin
          if (wr_go) begin
            if (wr_ok) begin
              for (int b = 0; b < $bits(strb_t); b++) begin
                if (lite.w_strb[b]) begin
                  regs_q[wr_idx][8*b +: 8] <= lite.w_data[8*b +: 8];
                end
              end
            end
            resp_q  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            state_q <= B_PEND;
          end else if (rd_go) begin
            // Out-of-range reads return zero
            rdata_q <= rd_ok ? regs_q[rd_idx] : '0;
            resp_q  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            state_q <= R_PEND;
          end
        end
        B_PEND: begin
          if (lite.b_ready) begin
            state_q <= axi_lite_pkg::IDLE;
          end
        end
        R_PEND: begin
          if (lite.r_ready) begin
            state_q <= axi_lite_pkg::IDLE;
          end
        end
        default: state_q <= axi_lite_pkg::IDLE;
      endcase
    end
  end

endmodule

// ==== hw/id_fifo.sv ====
// Queue of AXI IDs in request order, used by the reflector to put IDs back on responses
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module id_fifo #(
  parameter int unsigned DEPTH = `AXI_MAX_TXNS
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              push_i,
  input  axi_full_pkg::id_t data_i,
  input  logic              pop_i,
  output axi_full_pkg::id_t data_o,
  output logic              full_o,
  output logic              empty_o
);
  import axi_full_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  id_t              mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Wrap at DEPTH so non-power-of-two depths work
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -j 0 \
  --top-module axi_lite_reg_bridge_tb -f axi_lite_reg_bridge.f || exit 1
./obj_dir/Vaxi_lite_reg_bridge_tb | tee /dev/stderr | grep -qx "all tests passed" \
  && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/axi_lite_reg_bridge_asserts.sv ====
// Protocol checks on the bridge response channels, attached to the top level by bind
`timescale 1ns/1ps

module axi_lite_reg_bridge_asserts (
  input logic                clk_i,
  input logic                reset_i,
  input logic                b_valid_i,
  input logic                b_ready_i,
  input axi_full_pkg::id_t   b_id_i,
  input axi_full_pkg::resp_t b_resp_i,
  input logic                r_valid_i,
  input logic                r_ready_i,
  input axi_full_pkg::id_t   r_id_i,
  input axi_full_pkg::data_t r_data_i,
  input axi_full_pkg::resp_t r_resp_i,
  input logic                r_last_i
);

  // B stays up with the same payload until taken
  property b_hold_p;
    @(posedge clk_i) disable iff (reset_i)
      (b_valid_i && !b_ready_i) |=> (b_valid_i && $stable(b_id_i) && $stable(b_resp_i));
  endproperty

  property r_hold_p;
    @(posedge clk_i) disable iff (reset_i)
      (r_valid_i && !r_ready_i) |=>
        (r_valid_i && $stable(r_id_i) && $stable(r_data_i) && $stable(r_resp_i)
         && $stable(r_last_i));
  endproperty

  // Unknown counts as low before the first reset edge
  property quiet_in_reset_p;
    @(posedge clk_i) reset_i |-> ((b_valid_i !== 1'b1) && (r_valid_i !== 1'b1));
  endproperty

  property last_with_valid_p;
    @(posedge clk_i) disable iff (reset_i) r_last_i |-> r_valid_i;
  endproperty

  b_hold_a: assert property (b_hold_p) else $error("B response changed before b_ready_i");
  r_hold_a: assert property (r_hold_p) else $error("R beat changed before r_ready_i");
  quiet_a: assert property (quiet_in_reset_p) else $error("response valid high during reset");
  last_a: assert property (last_with_valid_p) else $error("r_last_o high without r_valid_o");

endmodule

// ==== sim/axi_lite_reg_bridge_tb.sv ====
// Table-driven testbench of the AXI to AXI-Lite register bridge, run from the project file list
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module axi_lite_reg_bridge_tb;
  import axi_full_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int MAX_STEPS = 16;
  localparam int SEL_AW = 0;
  localparam int SEL_W = 1;
  localparam int SEL_B = 2;
  localparam int SEL_AR = 3;
  localparam int SEL_R = 4;
  localparam bit WR = 1'b0;
  localparam bit RD = 1'b1;

  typedef struct packed {
    logic       is_read;
    id_t        id;
    addr_t      addr;
    len_t       len;
    data_t      data;
    strb_t      strb;
    resp_t      resp;
    logic [3:0] stall;
  } step_t;

  logic  clk_i = 1'b0;
  logic  reset_i;
  logic  aw_valid_i;
  logic  aw_ready_o;
  id_t   aw_id_i;
  addr_t aw_addr_i;
  len_t  aw_len_i;
  logic  w_valid_i;
  logic  w_ready_o;
  data_t w_data_i;
  strb_t w_strb_i;
  logic  w_last_i;
  logic  b_valid_o;
  logic  b_ready_i;
  id_t   b_id_o;
  resp_t b_resp_o;
  logic  ar_valid_i;
  logic  ar_ready_o;
  id_t   ar_id_i;
  addr_t ar_addr_i;
  len_t  ar_len_i;
  logic  r_valid_o;
  logic  r_ready_i;
  id_t   r_id_o;
  data_t r_data_o;
  resp_t r_resp_o;
  logic  r_last_o;

  step_t  steps [MAX_STEPS];
  string  names [MAX_STEPS];
  int     n_steps = 0;
  data_t  ref_regs [`REG_COUNT];
  integer seed = 32'hcea1fc23;
  int     errors = 0;
  int     checks = 0;
  int     b_count = 0;
  bit     abort = 1'b0;

  always #20 clk_i = ~clk_i;

  // B handshakes seen at the top level
  always @(negedge clk_i) begin
    if (b_valid_o && b_ready_i) begin
      b_count++;
    end
  end

  axi_lite_reg_bridge i_axi_lite_reg_bridge (.*);

  bind axi_lite_reg_bridge axi_lite_reg_bridge_asserts i_axi_lite_reg_bridge_asserts (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .b_valid_i (b_valid_o),
    .b_ready_i (b_ready_i),
    .b_id_i    (b_id_o),
    .b_resp_i  (b_resp_o),
    .r_valid_i (r_valid_o),
    .r_ready_i (r_ready_i),
    .r_id_i    (r_id_o),
    .r_data_i  (r_data_o),
    .r_resp_i  (r_resp_o),
    .r_last_i  (r_last_o)
  );

  task automatic add_step(input string name, input bit is_read, input id_t id, input addr_t addr,
                          input len_t len, input data_t data, input strb_t strb,
                          input resp_t resp, input logic [3:0] stall);
    steps[n_steps] = '{is_read, id, addr, len, data, strb, resp, stall};
    names[n_steps] = name;
    n_steps++;
  endtask

  // Reference model of the register file with byte strobes and range check
  task automatic model_write(input addr_t addr, input data_t data, input strb_t strb);
    if (addr < addr_t'(`REG_COUNT * 4)) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (strb[b]) begin
          ref_regs[int'(addr >> 2)][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  function automatic data_t expected_read(input addr_t addr);
    return (addr < addr_t'(`REG_COUNT * 4)) ? ref_regs[int'(addr >> 2)] : '0;
  endfunction

  function automatic logic signal_high(input int sel);
    case (sel)
      SEL_AW:  return aw_ready_o;
      SEL_W:   return w_ready_o;
      SEL_B:   return b_valid_o;
      SEL_AR:  return ar_ready_o;
      default: return r_valid_o;
    endcase
  endfunction

  function automatic logic [37:0] response_word(input int sel);
    return (sel == SEL_B) ? {b_id_o, b_resp_o, 32'h0} : {r_id_o, r_resp_o, r_data_o};
  endfunction

  task automatic check_value(input int idx, input string field, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("mismatch %s %s: expected %0h, actual %0h", names[idx], field, exp_v, act_v);
    end
  endtask

  // Polls on falling edges, where the handshake signals have settled
  task automatic wait_for(input int sel, input int idx, input string what, output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!signal_high(sel) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    ok = signal_high(sel);
    assert (ok) else begin
      errors++;
      abort = 1'b1;
      $display("error: step %s timed out waiting for %s", names[idx], what);
    end
  endtask

  // Response must stay put while ready is held low
  task automatic hold_steady(input int sel, input int idx, output bit ok);
    logic [37:0] held;
    ok = 1'b1;
    held = response_word(sel);
    for (int j = 0; j < int'(steps[idx].stall); j++) begin
      @(negedge clk_i);
      check_value(idx, "held valid", 64'd1, signal_high(sel));
      check_value(idx, "held payload", held, response_word(sel));
    end
    if (steps[idx].stall != '0) begin
      @(posedge clk_i);
      if (sel == SEL_B) begin
        b_ready_i <= 1'b1;
      end else begin
        r_ready_i <= 1'b1;
      end
      wait_for(sel, idx, "response after stall", ok);
    end
  endtask

  task automatic run_write(input int idx);
    step_t s;
    data_t d;
    addr_t a;
    bit    ok;
    int    b_start;
    s = steps[idx];
    b_start = b_count;
    @(posedge clk_i);
    b_ready_i  <= (s.stall == '0);
    aw_valid_i <= 1'b1;
    aw_id_i    <= s.id;
    aw_addr_i  <= s.addr;
    aw_len_i   <= s.len;
    wait_for(SEL_AW, idx, "aw_ready_o", ok);
    if (!ok) return;
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    for (int k = 0; k <= int'(s.len); k++) begin
      a = s.addr + addr_t'(4 * k);
      d = (k == 0) ? s.data : data_t'($random(seed));
      model_write(a, d, s.strb);
      w_valid_i <= 1'b1;
      w_data_i  <= d;
      w_strb_i  <= s.strb;
      w_last_i  <= (k == int'(s.len));
      wait_for(SEL_W, idx, "w_ready_o", ok);
      if (!ok) return;
      @(posedge clk_i);
    end
    w_valid_i <= 1'b0;
    w_last_i  <= 1'b0;
    wait_for(SEL_B, idx, "b_valid_o", ok);
    if (!ok) return;
    check_value(idx, "b_id", s.id, b_id_o);
    check_value(idx, "b_resp", s.resp, b_resp_o);
    hold_steady(SEL_B, idx, ok);
    if (!ok) return;
    @(posedge clk_i);
    // One merged B per burst
    check_value(idx, "b_count", 64'd1, b_count - b_start);
  endtask

  task automatic run_read(input int idx);
    step_t s;
    addr_t a;
    bit    ok;
    s = steps[idx];
    @(posedge clk_i);
    r_ready_i  <= (s.stall == '0);
    ar_valid_i <= 1'b1;
    ar_id_i    <= s.id;
    ar_addr_i  <= s.addr;
    ar_len_i   <= s.len;
    wait_for(SEL_AR, idx, "ar_ready_o", ok);
    if (!ok) return;
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    for (int k = 0; k <= int'(s.len); k++) begin
      a = s.addr + addr_t'(4 * k);
      wait_for(SEL_R, idx, "r_valid_o", ok);
      if (!ok) return;
      check_value(idx, "r_id", s.id, r_id_o);
      check_value(idx, "r_data", expected_read(a), r_data_o);
      check_value(idx, "r_resp", s.resp, r_resp_o);
      check_value(idx, "r_last", (k == int'(s.len)), r_last_o);
      if (k == 0) begin
        hold_steady(SEL_R, idx, ok);
        if (!ok) return;
      end
      @(posedge clk_i);
    end
  endtask

  initial begin
    reset_i    = 1'b1;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b1;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    r_ready_i  = 1'b1;
    for (int i = 0; i < `REG_COUNT; i++) begin
      ref_regs[i] = '0;
    end

    // Name, kind, ID, address, length, first data word, strobe, response, stall cycles
    add_step("single_write", WR, 4'd3, 32'h04, 8'd0, 32'h1234_5678, 4'hf, RESP_OKAY, 4'd0);
    add_step("single_read", RD, 4'd5, 32'h04, 8'd0, '0, '0, RESP_OKAY, 4'd0);
    add_step("partial_write", WR, 4'd1, 32'h04, 8'd0, 32'haabb_ccdd, 4'h5, RESP_OKAY, 4'd0);
    add_step("partial_read", RD, 4'd2, 32'h04, 8'd0, '0, '0, RESP_OKAY, 4'd0);
    add_step("burst_write", WR, 4'd7, 32'h10, 8'd3, 32'h0f1e_2d3c, 4'hf, RESP_OKAY, 4'd0);
    add_step("burst_read", RD, 4'd8, 32'h10, 8'd3, '0, '0, RESP_OKAY, 4'd0);
    add_step("oob_write", WR, 4'd9, 32'h40, 8'd0, 32'h5555_aaaa, 4'hf, RESP_SLVERR, 4'd0);
    add_step("oob_read", RD, 4'd10, 32'h40, 8'd1, '0, '0, RESP_SLVERR, 4'd0);
    add_step("cross_write", WR, 4'd11, 32'h38, 8'd3, 32'h7654_3210, 4'hf, RESP_SLVERR, 4'd0);
    add_step("cross_read", RD, 4'd12, 32'h38, 8'd1, '0, '0, RESP_OKAY, 4'd0);
    add_step("stall_write", WR, 4'd13, 32'h20, 8'd0, 32'h0bad_cafe, 4'hf, RESP_OKAY, 4'd5);
    add_step("stall_read", RD, 4'd14, 32'h20, 8'd1, '0, '0, RESP_OKAY, 4'd5);
    add_step("after_stall", RD, 4'd15, 32'h00, 8'd0, '0, '0, RESP_OKAY, 4'd0);

    repeat (3) @(posedge clk_i);
    // Nothing may handshake while reset is held
    @(negedge clk_i);
    checks++;
    assert ({aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o} === 5'b00000) else begin
      errors++;
      $display("mismatch reset_quiet: expected 0, actual %0h",
               {aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o});
    end
    @(posedge clk_i);
    reset_i <= 1'b0;

    for (int i = 0; i < n_steps && !abort; i++) begin
      if (steps[i].is_read) begin
        run_read(i);
      end else begin
        run_write(i);
      end
    end

    repeat (2) @(posedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
